//--- compile.f
+incdir+include
hw/adc_link_pkg.sv
hw/acq_sequencer.sv
hw/link_controller.sv
hw/tx_buffer.sv
hw/baud_timer.sv
hw/serial_shifter.sv
hw/adc_link_top.sv
tb/adc_link_sva.sv
tb/adc_link_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = adc_link_tb
FILELIST  = compile.f
BUILD     = obj_dir
PASS_TEXT = STATUS: PASS

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD)

//--- tb/adc_link_tb.sv
/* runs ten conversions with dsr dropped for the first byte of one of them
   the receiver model expects whole frames, so the run length scales with BIT_CYCLES */
`timescale 1ns/100ps
`default_nettype none

`include "adc_link_macros.svh"

module adc_link_tb;

	localparam int CONVERSIONS = 10;
	// this conversion loses its first byte to dsr low
	localparam int REJECT_CONV = 3;
	localparam int FRAME_TARGET = 2 * CONVERSIONS - 1;
	localparam int FRAME_SLOTS = `ADC_LINK_BYTE_W + 2;
	localparam int TIMEOUT_CYCLES = 60000;

	logic clock = 1'b0;
	logic reset = 1'b1;
	logic eoc = 1'b0;
	logic dsr = 1'b1;
	logic [`ADC_LINK_BYTE_W-1:0] data_in = '0;
	logic soc;
	logic load_dato;
	logic add_mpx2;
	logic mux_en;
	logic error;
	logic data_out;
	adc_link_pkg::channel_t canale;

	// model state
	logic [31:0] rng = 32'hf47e18dd;
	logic soc_q = 1'b0;
	int adc_cnt = 0;
	int conv_count = 0;
	logic reject_active = 1'b0;
	int rejects_seen = 0;
	logic [7:0] sample_lo = '0;
	logic [7:0] sample_hi = '0;
	// conversions started so far, sets the expected channel
	int socs_seen = 0;
	// bit 8 marks the second byte of a pair
	logic [8:0] expected_q[$];

	// receiver state
	logic rx_active = 1'b0;
	int rx_slot = 0;
	int rx_cnt = 0;
	logic rx_bad = 1'b0;
	logic [7:0] rx_shift = '0;
	int frames_rx = 0;

	int errors = 0;
	int timeouts = 0;
	int cycles = 0;

	adc_link_top dut0 (
		.clock     (clock),
		.reset     (reset),
		.eoc       (eoc),
		.dsr       (dsr),
		.data_in   (data_in),
		.soc       (soc),
		.load_dato (load_dato),
		.add_mpx2  (add_mpx2),
		.mux_en    (mux_en),
		.error     (error),
		.data_out  (data_out),
		.canale    (canale)
	);

	always #4 clock = ~clock;

	function automatic logic [31:0] next_random(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic flag_mismatch(input string what);
		errors++;
		$display("CHECK FAILED at %0t: %s", $time, what);
	endtask

	// ADC, data latch and dsr, all driven on the falling edge
	always @(negedge clock) begin : models
		int chan_expected;
		if (!reset) begin
			// eoc rises one cycle after soc and stays up for the busy time
			if (adc_cnt > 0) begin
				eoc <= 1'b1;
				adc_cnt--;
			end else begin
				eoc <= 1'b0;
			end
			if (soc && !soc_q) begin
				// scan order 0 up to the last channel, then wraps
				chan_expected = socs_seen % `ADC_LINK_CHANNELS;
				assert (int'(canale) == chan_expected)
					else flag_mismatch($sformatf("channel %0d at soc, expected %0d",
						canale, chan_expected));
				assert (!add_mpx2) else flag_mismatch("add_mpx2 high at soc");
				socs_seen++;
				rng = next_random(rng);
				adc_cnt = 3 + int'(rng[18:16]);
			end
			soc_q = soc;
			// sample is channel plus random bits, first byte keeps the channel
			if (load_dato) begin
				rng = next_random(rng);
				sample_lo = {rng[23:19], canale};
				sample_hi = rng[31:24];
				if (conv_count == REJECT_CONV) begin
					reject_active = 1'b1;
				end else begin
					expected_q.push_back({1'b0, sample_lo});
				end
				expected_q.push_back({1'b1, sample_hi});
				conv_count++;
			end
			// byte select moved on, so the rejected send is over
			if (reject_active && add_mpx2) begin
				assert (error) else flag_mismatch("error low after a rejected send");
				rejects_seen++;
				reject_active = 1'b0;
			end
			dsr <= !(reject_active && !add_mpx2);
			data_in <= add_mpx2 ? sample_hi : sample_lo;
		end
	end

	// serial receiver, every clock of every slot must hold the expected level
	always @(negedge clock) begin : receiver
		logic expected_bit;
		logic [8:0] entry;
		if (!rx_active && !reset && data_out === 1'b0) begin
			rx_active = 1'b1;
			rx_slot = 0;
			rx_cnt = 0;
			rx_bad = 1'b0;
			assert (!error) else flag_mismatch("error still set at frame start");
			if (expected_q.size() == 0) begin
				errors++;
				$display("frame started at %0t with no byte expected", $time);
				rx_shift = '0;
			end else begin
				entry = expected_q.pop_front();
				rx_shift = entry[7:0];
				assert (add_mpx2 == entry[8])
					else flag_mismatch($sformatf("add_mpx2 %0b for frame %0d", add_mpx2,
						frames_rx));
			end
		end
		if (rx_active) begin
			if (rx_slot == 0) begin
				expected_bit = 1'b0;
			end else if (rx_slot == FRAME_SLOTS - 1) begin
				expected_bit = 1'b1;
			end else begin
				expected_bit = rx_shift[7];
			end
			if (data_out !== expected_bit) begin
				rx_bad = 1'b1;
			end
			rx_cnt++;
			if (rx_cnt == `ADC_LINK_BIT_CYCLES) begin
				assert (!rx_bad)
					else flag_mismatch($sformatf("slot %0d of frame %0d wrong", rx_slot,
						frames_rx));
				if (rx_slot >= 1 && rx_slot <= `ADC_LINK_BYTE_W) begin
					rx_shift = rx_shift << 1;
				end
				rx_cnt = 0;
				rx_bad = 1'b0;
				rx_slot++;
				if (rx_slot == FRAME_SLOTS) begin
					rx_active = 1'b0;
					frames_rx++;
				end
			end
		end
	end

	initial begin
		repeat (5) @(negedge clock);
		assert (data_out && !soc && !load_dato && !add_mpx2 && !error && canale == '0)
			else flag_mismatch("outputs not at reset values");
		reset = 1'b0;
		while (frames_rx < FRAME_TARGET && cycles < TIMEOUT_CYCLES) begin
			@(posedge clock);
			cycles++;
		end
		if (frames_rx < FRAME_TARGET) begin
			timeouts++;
			$display("timed out with %0d of %0d frames received", frames_rx, FRAME_TARGET);
		end
		assert (expected_q.size() == 0)
			else flag_mismatch($sformatf("%0d bytes never sent", expected_q.size()));
		assert (rejects_seen == 1)
			else flag_mismatch($sformatf("%0d rejected sends seen", rejects_seen));
		$display("errors: %0d checks, %0d assertions, %0d timeouts", errors,
			dut0.sva0.fail_count, timeouts);
		if (errors == 0 && timeouts == 0 && dut0.sva0.fail_count == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tb/adc_link_sva.sv
/* protocol checks bound into the link top, all disabled while reset is high */
`timescale 1ns/100ps
`default_nettype none

module adc_link_sva (
	input logic clock,
	input logic reset,
	input logic soc,
	input logic load_dato,
	input logic mux_en,
	input logic error,
	input logic data_out,
	input logic load,
	input logic send,
	input logic line_busy
);

	int fail_count = 0;

	// latch strobe only inside a conversion
	latch_in_conv: assert property (@(posedge clock) disable iff (reset) load_dato |-> soc)
		else begin
			fail_count++;
			$error("load_dato high while soc is low");
		end

	// rejection and overrun flags never overlap a frame on the line
	error_idle: assert property (@(posedge clock) disable iff (reset) line_busy |-> !error)
		else begin
			fail_count++;
			$error("error high during a frame");
		end

	// load and send are separate strobes
	strobes_apart: assert property (@(posedge clock) disable iff (reset) !(load && send))
		else begin
			fail_count++;
			$error("load and send high together");
		end

	// mux released once the sample is latched
	mux_off: assert property (@(posedge clock) disable iff (reset) $fell(soc) |-> !mux_en)
		else begin
			fail_count++;
			$error("mux_en still high after soc fell");
		end

	// idle line is held at the stop level
	line_idle: assert property (@(posedge clock) disable iff (reset) !line_busy |-> data_out)
		else begin
			fail_count++;
			$error("data_out low with no frame in progress");
		end

endmodule

bind adc_link_top adc_link_sva sva0 (
	.clock     (clock),
	.reset     (reset),
	.soc       (soc),
	.load_dato (load_dato),
	.mux_en    (mux_en),
	.error     (error),
	.data_out  (data_out),
	.load      (load),
	.send      (send),
	.line_busy (line_busy)
);

`default_nettype wire

//--- hw/adc_link_top.sv
/* acquisition link top; ADC and its data latch are external, data_in must follow add_mpx2
   within the cycle after it changes */
`timescale 1ns/100ps
`default_nettype none

`include "adc_link_macros.svh"

module adc_link_top (
	input  logic                        clock,
	input  logic                        reset,
	input  logic                        eoc,
	input  logic                        dsr,
	input  logic [`ADC_LINK_BYTE_W-1:0] data_in,
	output logic                        soc,
	output logic                        load_dato,
	output logic                        add_mpx2,
	output logic                        mux_en,
	output logic                        error,
	output logic                        data_out,
	output adc_link_pkg::channel_t      canale
);

	// sequencer to controller handshake
	logic pair_request;
	logic pair_done;
	// controller to buffer strobes
	logic load;
	logic send;
	logic frame_done;
	// buffer to shifter
	logic                        tx_start;
	logic                        tx_end;
	logic [`ADC_LINK_BYTE_W-1:0] tx_byte;
	// bit timing
	logic line_busy;
	logic bit_tick;

	acq_sequencer u_sequencer (
		.clock        (clock),
		.reset        (reset),
		.eoc          (eoc),
		.pair_done    (pair_done),
		.mux_en       (mux_en),
		.soc          (soc),
		.load_dato    (load_dato),
		.pair_request (pair_request),
		.canale       (canale)
	);

	link_controller u_controller (
		.clock        (clock),
		.reset        (reset),
		.pair_request (pair_request),
		.frame_done   (frame_done),
		.load         (load),
		.send         (send),
		.add_mpx2     (add_mpx2),
		.pair_done    (pair_done)
	);

	tx_buffer u_buffer (
		.clock      (clock),
		.reset      (reset),
		.load       (load),
		.send       (send),
		.dsr        (dsr),
		.tx_end     (tx_end),
		.data_in    (data_in),
		.tx_start   (tx_start),
		.frame_done (frame_done),
		.error      (error),
		.tx_byte    (tx_byte)
	);

	baud_timer u_baud (
		.clock     (clock),
		.reset     (reset),
		.line_busy (line_busy),
		.bit_tick  (bit_tick)
	);

	serial_shifter u_shifter (
		.clock     (clock),
		.reset     (reset),
		.tx_start  (tx_start),
		.bit_tick  (bit_tick),
		.tx_byte   (tx_byte),
		.line_busy (line_busy),
		.tx_end    (tx_end),
		.data_out  (data_out)
	);

endmodule

`default_nettype wire

//--- hw/serial_shifter.sv
/* async frame of start bit, data MSB first and one stop bit; tx_byte must not change
   between tx_start and tx_end, and a tx_start while busy is ignored */
`timescale 1ns/100ps
`default_nettype none

`include "adc_link_macros.svh"

module serial_shifter (
	input  logic                        clock,
	input  logic                        reset,
	input  logic                        tx_start,
	input  logic                        bit_tick,
	input  logic [`ADC_LINK_BYTE_W-1:0] tx_byte,
	output logic                        line_busy,
	output logic                        tx_end,
	output logic                        data_out
);

	localparam int IDX_W = $clog2(`ADC_LINK_BYTE_W);

	adc_link_pkg::bit_slot_e slot;
	// data bit on the line, counts down for MSB first
	logic [IDX_W-1:0] bit_idx;

	always_ff @(posedge clock) begin
		if (reset) begin
			slot <= adc_link_pkg::slot_idle;
		end else begin
			case (slot)
				adc_link_pkg::slot_idle: begin
					if (tx_start) begin
						slot <= adc_link_pkg::slot_start;
					end
				end
				adc_link_pkg::slot_start: begin
					if (bit_tick) begin
						slot <= adc_link_pkg::slot_data;
					end
				end
				adc_link_pkg::slot_data: begin
					// leave after the LSB period
					if (bit_tick && bit_idx == '0) begin
						slot <= adc_link_pkg::slot_stop;
					end
				end
				adc_link_pkg::slot_stop: begin
					if (bit_tick) begin
						slot <= adc_link_pkg::slot_idle;
					end
				end
				default: slot <= adc_link_pkg::slot_idle;
			endcase
		end
	end

	// preset to the MSB during the start bit
	always_ff @(posedge clock) begin
		if (reset) begin
			bit_idx <= '0;
		end else if (slot == adc_link_pkg::slot_start) begin
			bit_idx <= IDX_W'(`ADC_LINK_BYTE_W - 1);
		end else if (slot == adc_link_pkg::slot_data && bit_tick) begin
			bit_idx <= bit_idx - 1'b1;
		end
	end

	// line is high when idle and during stop
	always_comb begin
		case (slot)
			adc_link_pkg::slot_start: data_out = 1'b0;
			adc_link_pkg::slot_data:  data_out = tx_byte[bit_idx];
			default:                  data_out = 1'b1;
		endcase
	end

	assign line_busy = (slot != adc_link_pkg::slot_idle);

	// final clock of the stop slot
	assign tx_end = (slot == adc_link_pkg::slot_stop) && bit_tick;

endmodule

`default_nettype wire

//--- hw/baud_timer.sv
/* bit period counter, restarts from zero at every frame start */
`timescale 1ns/100ps
`default_nettype none

`include "adc_link_macros.svh"

module baud_timer (
	input  logic clock,
	input  logic reset,
	input  logic line_busy,
	output logic bit_tick
);

	localparam int CNT_W = $clog2(`ADC_LINK_BIT_CYCLES);
	localparam logic [CNT_W-1:0] LAST_COUNT = CNT_W'(`ADC_LINK_BIT_CYCLES - 1);

	logic [CNT_W-1:0] count;

	// held at zero while idle so the first slot is full length
	always_ff @(posedge clock) begin
		if (reset || !line_busy) begin
			count <= '0;
		end else if (count == LAST_COUNT) begin
			count <= '0;
		end else begin
			count <= count + 1'b1;
		end
	end

	// last clock of each bit slot
	assign bit_tick = line_busy && (count == LAST_COUNT);

endmodule

`default_nettype wire

//--- hw/tx_buffer.sv
/* one-byte transmit buffer; dsr is sampled only on the send strobe and must be synchronous
   a rejected send drops the byte, it is not retried */
`timescale 1ns/100ps
`default_nettype none

`include "adc_link_macros.svh"

module tx_buffer (
	input  logic                        clock,
	input  logic                        reset,
	input  logic                        load,
	input  logic                        send,
	input  logic                        dsr,
	input  logic                        tx_end,
	input  logic [`ADC_LINK_BYTE_W-1:0] data_in,
	output logic                        tx_start,
	output logic                        frame_done,
	output logic                        error,
	output logic [`ADC_LINK_BYTE_W-1:0] tx_byte
);

	// byte held, stays set while the frame is on the line
	logic full;
	// send with a byte present and receiver ready
	logic accept;
	// frame end for a rejected send, one cycle late
	logic reject_done;

	assign accept = send && full && dsr;

	always_ff @(posedge clock) begin
		if (reset) begin
			full        <= 1'b0;
			error       <= 1'b0;
			tx_start    <= 1'b0;
			reject_done <= 1'b0;
		end else begin
			tx_start    <= accept;
			reject_done <= send && !accept;
			if (tx_end) begin
				full <= 1'b0;
			end
			// load into a full buffer is an overrun, old byte kept
			if (load) begin
				if (full) begin
					error <= 1'b1;
				end else begin
					full <= 1'b1;
				end
			end
			if (send) begin
				if (accept) begin
					error <= 1'b0;
				end else begin
					error <= 1'b1;
					full  <= 1'b0;
				end
			end
		end
	end

	// payload only written into an empty buffer, so stable during a frame
	always_ff @(posedge clock) begin
		if (load && !full) begin
			tx_byte <= data_in;
		end
	end

	// exactly one frame_done per send
	assign frame_done = reject_done || tx_end;

endmodule

`default_nettype wire

//--- hw/link_controller.sv
/* sends the two bytes of each sample through load and send strobes
   a rejected byte still ends with frame_done, so the pair always completes */
`timescale 1ns/100ps
`default_nettype none

module link_controller (
	input  logic clock,
	input  logic reset,
	input  logic pair_request,
	input  logic frame_done,
	output logic load,
	output logic send,
	output logic add_mpx2,
	output logic pair_done
);

	adc_link_pkg::link_state_e state;
	adc_link_pkg::link_state_e next_state;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= adc_link_pkg::link_idle;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			adc_link_pkg::link_idle: begin
				if (pair_request) begin
					next_state = adc_link_pkg::link_load_byte;
				end
			end
			// load strobe, then send strobe in the following cycle
			adc_link_pkg::link_load_byte: next_state = adc_link_pkg::link_send_byte;
			adc_link_pkg::link_send_byte: next_state = adc_link_pkg::link_wait_frame;
			adc_link_pkg::link_wait_frame: begin
				// add_mpx2 still shows which byte just finished
				if (frame_done) begin
					if (add_mpx2) begin
						next_state = adc_link_pkg::link_finish;
					end else begin
						next_state = adc_link_pkg::link_next_byte;
					end
				end
			end
			// one cycle for the external byte mux to switch over
			adc_link_pkg::link_next_byte: next_state = adc_link_pkg::link_load_byte;
			// pair_done goes out here, the sequencer drops its request next cycle
			adc_link_pkg::link_finish:    next_state = adc_link_pkg::link_idle;
			default:                      next_state = adc_link_pkg::link_idle;
		endcase
	end

	// byte select flips on every frame end, so it is back low after the second
	always_ff @(posedge clock) begin
		if (reset) begin
			add_mpx2 <= 1'b0;
		end else if (state == adc_link_pkg::link_wait_frame && frame_done) begin
			add_mpx2 <= !add_mpx2;
		end
	end

	assign load = (state == adc_link_pkg::link_load_byte);
	assign send = (state == adc_link_pkg::link_send_byte);

	// single cycle, the finish state is never held
	assign pair_done = (state == adc_link_pkg::link_finish);

endmodule

`default_nettype wire

//--- hw/acq_sequencer.sv
/* scans the channels one conversion at a time; eoc must rise and then fall for each soc,
   and the sequencer stalls on pair_request until pair_done comes back */
`timescale 1ns/100ps
`default_nettype none

`include "adc_link_macros.svh"

module acq_sequencer (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   eoc,
	input  logic                   pair_done,
	output logic                   mux_en,
	output logic                   soc,
	output logic                   load_dato,
	output logic                   pair_request,
	output adc_link_pkg::channel_t canale
);

	adc_link_pkg::seq_state_e state;
	adc_link_pkg::seq_state_e next_state;

	// eoc has gone high in this conversion
	logic eoc_seen;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= adc_link_pkg::seq_settle_a;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			// two cycles for the mux output to settle
			adc_link_pkg::seq_settle_a:   next_state = adc_link_pkg::seq_settle_b;
			adc_link_pkg::seq_settle_b:   next_state = adc_link_pkg::seq_start_conv;
			adc_link_pkg::seq_start_conv: next_state = adc_link_pkg::seq_wait_conv;
			adc_link_pkg::seq_wait_conv: begin
				// only a falling eoc after a rising one ends the conversion
				if (eoc_seen && !eoc) begin
					next_state = adc_link_pkg::seq_latch;
				end
			end
			adc_link_pkg::seq_latch:      next_state = adc_link_pkg::seq_advance;
			adc_link_pkg::seq_advance:    next_state = adc_link_pkg::seq_request;
			adc_link_pkg::seq_request:    next_state = adc_link_pkg::seq_wait_pair;
			adc_link_pkg::seq_wait_pair: begin
				if (pair_done) begin
					next_state = adc_link_pkg::seq_settle_a;
				end
			end
			default:                      next_state = adc_link_pkg::seq_settle_a;
		endcase
	end

	// eoc tracking, cleared outside the conversion wait
	always_ff @(posedge clock) begin
		if (reset) begin
			eoc_seen <= 1'b0;
		end else if (state == adc_link_pkg::seq_wait_conv) begin
			if (eoc) begin
				eoc_seen <= 1'b1;
			end
		end else begin
			eoc_seen <= 1'b0;
		end
	end

	// channel steps while the latch strobe is out, visible from advance on
	always_ff @(posedge clock) begin
		if (reset) begin
			canale <= '0;
		end else if (state == adc_link_pkg::seq_latch) begin
			if (canale == adc_link_pkg::channel_t'(`ADC_LINK_CHANNELS - 1)) begin
				canale <= '0;
			end else begin
				canale <= canale + 1'b1;
			end
		end
	end

	// mux stays enabled from settle until the sample is latched
	assign mux_en = (state == adc_link_pkg::seq_settle_a) ||
		(state == adc_link_pkg::seq_settle_b) ||
		(state == adc_link_pkg::seq_start_conv) ||
		(state == adc_link_pkg::seq_wait_conv);

	// soc covers the whole conversion including the latch cycle
	assign soc = (state == adc_link_pkg::seq_start_conv) ||
		(state == adc_link_pkg::seq_wait_conv) ||
		(state == adc_link_pkg::seq_latch);

	assign load_dato = (state == adc_link_pkg::seq_latch);

	// level held until the pair has gone out
	assign pair_request = (state == adc_link_pkg::seq_request) ||
		(state == adc_link_pkg::seq_wait_pair);

endmodule

`default_nettype wire

//--- hw/adc_link_pkg.sv
/* state encodings of the link FSMs and the channel type */
`default_nettype none

`include "adc_link_macros.svh"

package adc_link_pkg;

	// multiplexer channel number
	typedef logic [`ADC_LINK_CHAN_W-1:0] channel_t;

	// acquisition sequencer
	typedef enum logic [2:0] {
		seq_settle_a,
		seq_settle_b,
		seq_start_conv,
		seq_wait_conv,
		seq_latch,
		seq_advance,
		seq_request,
		seq_wait_pair
	} seq_state_e;

	// two-byte transfer controller
	typedef enum logic [2:0] {
		link_idle,
		link_load_byte,
		link_send_byte,
		link_wait_frame,
		link_next_byte,
		link_finish
	} link_state_e;

	// serial frame slot currently on the line
	typedef enum logic [1:0] {
		slot_idle,
		slot_start,
		slot_data,
		slot_stop
	} bit_slot_e;

endpackage

`default_nettype wire

//--- include/adc_link_macros.svh
/* sizes for the acquisition link; BIT_CYCLES is clocks per serial bit, fixed at build time
   CHAN_W must be wide enough to count CHANNELS-1 */
`ifndef ADC_LINK_MACROS_SVH
`define ADC_LINK_MACROS_SVH

// analog multiplexer inputs scanned in turn
`define ADC_LINK_CHANNELS 8

// channel number width
`define ADC_LINK_CHAN_W 3

// serial payload, one byte per frame
`define ADC_LINK_BYTE_W 8

// clocks per serial bit slot
// 104 gives 9600 baud from roughly 1 MHz
`define ADC_LINK_BIT_CYCLES 104

`endif
